// ==== Bender.yml ====
package:
  name: line_xfer

export_include_dirs:
  - rtl

sources:
  - rtl/line_xfer_pkg.sv
  - rtl/xfer_cfg_regs.sv
  - rtl/line_serializer.sv
  - rtl/lite_bus_master.sv
  - rtl/word_mem.sv
  - rtl/line_xfer_top.sv
  - target: simulation
    files:
      - sim/tb_line_xfer.sv

// ==== rtl/line_serializer.sv ====
// One line in flight; starts while busy are dropped, write wins over read, BASE latched at start.
`timescale 1ns/1ps
`include "line_xfer_defines.svh"

module line_serializer (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_start_read,
    input  logic                 i_start_write,
    input  line_xfer_pkg::addr_t i_line_addr,
    input  line_xfer_pkg::line_t i_line_wdata,
    input  line_xfer_pkg::addr_t i_base,
    input  logic                 i_beat_done,
    input  line_xfer_pkg::word_t i_beat_rdata,
    input  logic                 i_beat_fault,
    output logic                 o_beat_start,
    output line_xfer_pkg::addr_t o_beat_addr,
    output line_xfer_pkg::word_t o_beat_wdata,
    output logic                 o_beat_we,
    output line_xfer_pkg::line_t o_line_rdata,
    output logic                 o_done,
    output logic                 o_fault,
    output logic                 o_rd_fault,
    output logic                 o_wr_fault,
    output logic                 o_busy
);

    line_xfer_pkg::ser_state_e state_q;
    line_xfer_pkg::beat_idx_t  beat_q;
    logic                      we_q;
    logic                      fault_q;
    line_xfer_pkg::line_t      line_q;
    line_xfer_pkg::addr_t      line_base_q;
    logic                      accept;

    assign accept = (state_q == line_xfer_pkg::SER_IDLE) && (i_start_read || i_start_write);

    // --------------------
    // Beat sequencing.
    // --------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= line_xfer_pkg::SER_IDLE;
            beat_q  <= '0;
            we_q    <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            case (state_q)
                line_xfer_pkg::SER_IDLE: begin
                    if (accept) begin
                        state_q <= line_xfer_pkg::SER_BEAT;
                        beat_q  <= '0;
                        we_q    <= i_start_write;
                        fault_q <= 1'b0;
                    end
                end
                line_xfer_pkg::SER_BEAT: state_q <= line_xfer_pkg::SER_WAIT;
                line_xfer_pkg::SER_WAIT: begin
                    if (i_beat_done) begin
                        fault_q <= fault_q | i_beat_fault;
                        if (beat_q == line_xfer_pkg::beat_idx_t'(`XFER_BEATS - 1)) begin
                            state_q <= line_xfer_pkg::SER_FINISH;
                        end else begin
                            beat_q  <= beat_q + 1'b1;
                            state_q <= line_xfer_pkg::SER_BEAT;
                        end
                    end
                end
                default: state_q <= line_xfer_pkg::SER_IDLE;
            endcase
        end
    end

    // Line data and address base; read words land in their beat slot.
    always_ff @(posedge clk) begin
        if (accept) begin
            line_q      <= i_line_wdata;
            line_base_q <= i_base + (i_line_addr << `XFER_BEAT_CNT_W);
        end else if (state_q == line_xfer_pkg::SER_WAIT && i_beat_done && !we_q) begin
            line_q[beat_q*`XFER_WORD_W +: `XFER_WORD_W] <= i_beat_rdata;
        end
    end

    // --------------------
    // Outputs.
    // --------------------
    assign o_beat_start = (state_q == line_xfer_pkg::SER_BEAT);
    assign o_beat_addr  = line_base_q + line_xfer_pkg::addr_t'(beat_q);
    assign o_beat_wdata = line_q[beat_q*`XFER_WORD_W +: `XFER_WORD_W];
    assign o_beat_we    = we_q;
    assign o_line_rdata = line_q;

    assign o_done     = (state_q == line_xfer_pkg::SER_FINISH);
    assign o_fault    = o_done & fault_q;
    assign o_rd_fault = o_fault & ~we_q;
    assign o_wr_fault = o_fault & we_q;
    assign o_busy     = (state_q != line_xfer_pkg::SER_IDLE);

endmodule

// ==== rtl/line_xfer_defines.svh ====
// Sizes are fixed for 32-bit beats and 512-bit lines; depth and counter widths must stay consistent.
`ifndef LINE_XFER_DEFINES_SVH
`define LINE_XFER_DEFINES_SVH

// --------------------
// Bus and line geometry.
// --------------------
`define XFER_WORD_W     32
`define XFER_LINE_W     512
`define XFER_BEATS      16
`define XFER_BEAT_CNT_W 4
`define XFER_ADDR_W     32

// --------------------
// On-chip memory.
// --------------------
`define XFER_MEM_WORDS  256
`define XFER_MEM_IDX_W  8

// Completed line counter in STATUS[31:16].
`define XFER_LCNT_W     16

`endif

// ==== rtl/line_xfer_pkg.sv ====
// Shared types only; widths come from the defines header, and state names carry a block prefix.
`include "line_xfer_defines.svh"

package line_xfer_pkg;

    // --------------------
    // Vector types.
    // --------------------
    typedef logic [`XFER_WORD_W-1:0]     word_t;
    typedef logic [`XFER_LINE_W-1:0]     line_t;
    typedef logic [`XFER_ADDR_W-1:0]     addr_t;
    typedef logic [`XFER_BEAT_CNT_W-1:0] beat_idx_t;

    // Request from the bus master to the word memory.
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
        logic  req;
    } mem_req_t;

    // Registered memory response with access status.
    typedef struct packed {
        word_t rdata;
        logic  access_ok;
        logic  rd_ok;
        logic  wr_ok;
    } mem_rsp_t;

    // --------------------
    // State machines.
    // --------------------
    typedef enum logic [1:0] {SER_IDLE, SER_BEAT, SER_WAIT, SER_FINISH} ser_state_e;

    typedef enum logic [1:0] {BUS_IDLE, BUS_REQ, BUS_RSP} bus_state_e;

endpackage

// ==== rtl/line_xfer_top.sv ====
// One line at a time with no back-pressure beyond o_busy; line index is in 16-word units.
`timescale 1ns/1ps

module line_xfer_top (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_start_read,
    input  logic                 i_start_write,
    input  line_xfer_pkg::addr_t i_line_addr,
    input  line_xfer_pkg::line_t i_line_wdata,
    input  logic                 i_cfg_we,
    input  logic                 i_cfg_sel,
    input  line_xfer_pkg::word_t i_cfg_wdata,
    output line_xfer_pkg::word_t o_cfg_rdata,
    output line_xfer_pkg::line_t o_line_rdata,
    output logic                 o_done,
    output logic                 o_fault,
    output logic                 o_busy
);

    // --------------------
    // Internal nets.
    // --------------------
    line_xfer_pkg::addr_t     s_base;
    logic                     s_rd_fault;
    logic                     s_wr_fault;

    // Serializer to bus master.
    logic                     s_beat_start;
    line_xfer_pkg::addr_t     s_beat_addr;
    line_xfer_pkg::word_t     s_beat_wdata;
    logic                     s_beat_we;
    logic                     s_beat_done;
    line_xfer_pkg::word_t     s_beat_rdata;
    logic                     s_beat_fault;

    // Memory port.
    line_xfer_pkg::mem_req_t  s_mem_req;
    line_xfer_pkg::mem_rsp_t  s_mem_rsp;

    xfer_cfg_regs xfer_cfg_regs_i (
        .clk         (clk),          .i_rst_n     (i_rst_n),
        .i_cfg_we    (i_cfg_we),     .i_cfg_sel   (i_cfg_sel),
        .i_cfg_wdata (i_cfg_wdata),  .i_line_done (o_done),
        .i_rd_fault  (s_rd_fault),   .i_wr_fault  (s_wr_fault),
        .o_cfg_rdata (o_cfg_rdata),  .o_base      (s_base)
    );

    line_serializer line_serializer_i (
        .clk           (clk),           .i_rst_n       (i_rst_n),
        .i_start_read  (i_start_read),  .i_start_write (i_start_write),
        .i_line_addr   (i_line_addr),   .i_line_wdata  (i_line_wdata),
        .i_base        (s_base),        .i_beat_done   (s_beat_done),
        .i_beat_rdata  (s_beat_rdata),  .i_beat_fault  (s_beat_fault),
        .o_beat_start  (s_beat_start),  .o_beat_addr   (s_beat_addr),
        .o_beat_wdata  (s_beat_wdata),  .o_beat_we     (s_beat_we),
        .o_line_rdata  (o_line_rdata),  .o_done        (o_done),
        .o_fault       (o_fault),       .o_rd_fault    (s_rd_fault),
        .o_wr_fault    (s_wr_fault),    .o_busy        (o_busy)
    );

    lite_bus_master lite_bus_master_i (
        .clk          (clk),           .i_rst_n      (i_rst_n),
        .i_beat_start (s_beat_start),  .i_beat_addr  (s_beat_addr),
        .i_beat_wdata (s_beat_wdata),  .i_beat_we    (s_beat_we),
        .i_mem_rsp    (s_mem_rsp),     .o_mem_req    (s_mem_req),
        .o_beat_done  (s_beat_done),   .o_beat_rdata (s_beat_rdata),
        .o_beat_fault (s_beat_fault)
    );

    word_mem word_mem_i (
        .clk       (clk),        .i_rst_n   (i_rst_n),
        .i_mem_req (s_mem_req),  .o_mem_rsp (s_mem_rsp)
    );

endmodule

// ==== rtl/lite_bus_master.sv ====
// Single outstanding beat; the memory must answer exactly one cycle after the request strobe.
`timescale 1ns/1ps

module lite_bus_master (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_beat_start,
    input  line_xfer_pkg::addr_t    i_beat_addr,
    input  line_xfer_pkg::word_t    i_beat_wdata,
    input  logic                    i_beat_we,
    input  line_xfer_pkg::mem_rsp_t i_mem_rsp,
    output line_xfer_pkg::mem_req_t o_mem_req,
    output logic                    o_beat_done,
    output line_xfer_pkg::word_t    o_beat_rdata,
    output logic                    o_beat_fault
);

    line_xfer_pkg::bus_state_e state_q;
    line_xfer_pkg::addr_t      addr_q;
    line_xfer_pkg::word_t      wdata_q;
    logic                      we_q;
    logic                      rsp_bad;

    // --------------------
    // Beat FSM.
    // --------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= line_xfer_pkg::BUS_IDLE;
        end else begin
            case (state_q)
                line_xfer_pkg::BUS_IDLE: begin
                    if (i_beat_start) begin
                        state_q <= line_xfer_pkg::BUS_REQ;
                    end
                end
                line_xfer_pkg::BUS_REQ: state_q <= line_xfer_pkg::BUS_RSP;
                default: state_q <= line_xfer_pkg::BUS_IDLE;
            endcase
        end
    end

    // Capture the beat when it is handed over.
    always_ff @(posedge clk) begin
        if (state_q == line_xfer_pkg::BUS_IDLE && i_beat_start) begin
            addr_q  <= i_beat_addr;
            wdata_q <= i_beat_wdata;
            we_q    <= i_beat_we;
        end
    end

    // Request is live for the one REQ cycle.
    assign o_mem_req = '{
        addr:  addr_q,
        wdata: wdata_q,
        we:    we_q,
        req:   (state_q == line_xfer_pkg::BUS_REQ)
    };

    // --------------------
    // Response handling.
    // --------------------
    // A beat faults on a bad access or a missing direction ack.
    assign rsp_bad = ~i_mem_rsp.access_ok | (we_q ? ~i_mem_rsp.wr_ok : ~i_mem_rsp.rd_ok);

    assign o_beat_done  = (state_q == line_xfer_pkg::BUS_RSP);
    assign o_beat_rdata = i_mem_rsp.rdata;
    assign o_beat_fault = o_beat_done & rsp_bad;

endmodule

// ==== rtl/word_mem.sv ====
// 256 words, contents undefined after reset; out-of-range writes are dropped and reads give zero.
`timescale 1ns/1ps
`include "line_xfer_defines.svh"

module word_mem (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  line_xfer_pkg::mem_req_t i_mem_req,
    output line_xfer_pkg::mem_rsp_t o_mem_rsp
);

    line_xfer_pkg::word_t        mem [0:`XFER_MEM_WORDS-1];
    logic [`XFER_MEM_IDX_W-1:0]  idx;
    logic                        in_range;

    assign idx      = i_mem_req.addr[`XFER_MEM_IDX_W-1:0];
    assign in_range = (i_mem_req.addr < `XFER_MEM_WORDS);

    // Storage and read data.
    always_ff @(posedge clk) begin
        if (i_mem_req.req) begin
            if (in_range && i_mem_req.we) begin
                mem[idx] <= i_mem_req.wdata;
            end
            o_mem_rsp.rdata <= in_range ? mem[idx] : '0;
        end
    end

    // Status flags, valid the cycle after a request.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_mem_rsp.access_ok <= 1'b0;
            o_mem_rsp.rd_ok     <= 1'b0;
            o_mem_rsp.wr_ok     <= 1'b0;
        end else begin
            o_mem_rsp.access_ok <= i_mem_req.req & in_range;
            o_mem_rsp.rd_ok     <= i_mem_req.req & in_range & ~i_mem_req.we;
            o_mem_rsp.wr_ok     <= i_mem_req.req & in_range & i_mem_req.we;
        end
    end

endmodule

// ==== rtl/xfer_cfg_regs.sv ====
// One-bit select only (0 BASE, 1 STATUS); a STATUS write clears faults and count, beating done.
`timescale 1ns/1ps
`include "line_xfer_defines.svh"

module xfer_cfg_regs (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_cfg_we,
    input  logic                 i_cfg_sel,
    input  line_xfer_pkg::word_t i_cfg_wdata,
    input  logic                 i_line_done,
    input  logic                 i_rd_fault,
    input  logic                 i_wr_fault,
    output line_xfer_pkg::word_t o_cfg_rdata,
    output line_xfer_pkg::addr_t o_base
);

    localparam int PAD_W = `XFER_WORD_W - `XFER_LCNT_W - 2;

    line_xfer_pkg::addr_t     base_q;
    logic                     rd_fault_q;
    logic                     wr_fault_q;
    logic [`XFER_LCNT_W-1:0]  lcnt_q;

    // --------------------
    // Register updates.
    // --------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            base_q     <= '0;
            rd_fault_q <= 1'b0;
            wr_fault_q <= 1'b0;
            lcnt_q     <= '0;
        end else begin
            if (i_cfg_we && !i_cfg_sel) begin
                base_q <= line_xfer_pkg::addr_t'(i_cfg_wdata);
            end

            // Clear wins over a done pulse in the same cycle.
            if (i_cfg_we && i_cfg_sel) begin
                rd_fault_q <= 1'b0;
                wr_fault_q <= 1'b0;
                lcnt_q     <= '0;
            end else if (i_line_done) begin
                rd_fault_q <= rd_fault_q | i_rd_fault;
                wr_fault_q <= wr_fault_q | i_wr_fault;
                lcnt_q     <= lcnt_q + 1'b1;
            end
        end
    end

    // Combinational readback.
    assign o_cfg_rdata = i_cfg_sel ? {lcnt_q, {PAD_W{1'b0}}, wr_fault_q, rd_fault_q}
                                   : line_xfer_pkg::word_t'(base_q);

    assign o_base = base_q;

endmodule

// ==== sim/tb_line_xfer.sv ====
// Memory starts undefined, so readbacks compare only words this testbench has written.
`timescale 1ns/1ps
`include "line_xfer_defines.svh"

module tb_line_xfer;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int LINE_CYCLES    = 49;

    logic                 clk;
    logic                 i_rst_n;
    logic                 i_start_read;
    logic                 i_start_write;
    line_xfer_pkg::addr_t i_line_addr;
    line_xfer_pkg::line_t i_line_wdata;
    logic                 i_cfg_we;
    logic                 i_cfg_sel;
    line_xfer_pkg::word_t i_cfg_wdata;
    line_xfer_pkg::word_t o_cfg_rdata;
    line_xfer_pkg::line_t o_line_rdata;
    logic                 o_done;
    logic                 o_fault;
    logic                 o_busy;

    // Reference copy of the memory and which words hold known data.
    line_xfer_pkg::word_t shadow [0:`XFER_MEM_WORDS-1];
    logic                 known  [0:`XFER_MEM_WORDS-1];

    line_xfer_pkg::addr_t base_now;
    logic [31:0]          rng;
    int                   errors     = 0;
    int                   tests_ok   = 0;
    int                   tests_bad  = 0;
    int                   lines_done = 0;
    int                   cycle_cnt  = 0;

    line_xfer_top line_xfer_top_i (
        .clk           (clk),           .i_rst_n       (i_rst_n),
        .i_start_read  (i_start_read),  .i_start_write (i_start_write),
        .i_line_addr   (i_line_addr),   .i_line_wdata  (i_line_wdata),
        .i_cfg_we      (i_cfg_we),      .i_cfg_sel     (i_cfg_sel),
        .i_cfg_wdata   (i_cfg_wdata),   .o_cfg_rdata   (o_cfg_rdata),
        .o_line_rdata  (o_line_rdata),  .o_done        (o_done),
        .o_fault       (o_fault),       .o_busy        (o_busy)
    );

    // --------------------
    // Clock and timeout.
    // --------------------
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------
    // Helpers.
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_val(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic next_line(output line_xfer_pkg::line_t l);
        int i;
        for (i = 0; i < `XFER_BEATS; i++) begin
            rng = xorshift32(rng);
            l[i*`XFER_WORD_W +: `XFER_WORD_W] = rng;
        end
    endtask

    task automatic cfg_write(input logic sel, input line_xfer_pkg::word_t data);
        @(posedge clk);
        #1;
        i_cfg_we    = 1'b1;
        i_cfg_sel   = sel;
        i_cfg_wdata = data;
        @(posedge clk);
        #1;
        i_cfg_we = 1'b0;
        if (!sel) base_now = data;
    endtask

    // STATUS takes the done pulse on the edge after o_done.
    task automatic read_status(output line_xfer_pkg::word_t v);
        @(posedge clk);
        #1;
        i_cfg_sel = 1'b1;
        #1;
        v = o_cfg_rdata;
    endtask

    // Word address = base + 16 * line index + beat; out-of-range words are dropped.
    task automatic record_write(input line_xfer_pkg::addr_t idx, input line_xfer_pkg::line_t l);
        int k;
        line_xfer_pkg::addr_t a;
        for (k = 0; k < `XFER_BEATS; k++) begin
            a = base_now + idx * `XFER_BEATS + k;
            if (a < `XFER_MEM_WORDS) begin
                shadow[a] = l[k*`XFER_WORD_W +: `XFER_WORD_W];
                known[a]  = 1'b1;
            end
        end
    endtask

    task automatic expected_line(input line_xfer_pkg::addr_t idx,
                                 output line_xfer_pkg::line_t exp,
                                 output line_xfer_pkg::line_t mask);
        int k;
        line_xfer_pkg::addr_t a;
        exp  = '0;
        mask = '0;
        for (k = 0; k < `XFER_BEATS; k++) begin
            a = base_now + idx * `XFER_BEATS + k;
            if (a < `XFER_MEM_WORDS && known[a]) begin
                exp[k*`XFER_WORD_W +: `XFER_WORD_W]  = shadow[a];
                mask[k*`XFER_WORD_W +: `XFER_WORD_W] = '1;
            end
        end
    endtask

    // One line transfer, counting cycles from the accepted strobe to o_done.
    task automatic run_line(input logic we, input line_xfer_pkg::addr_t idx,
                            input line_xfer_pkg::line_t wdata,
                            output line_xfer_pkg::line_t rdata,
                            output logic fault, output int cycles);
        @(posedge clk);
        #1;
        i_start_write = we;
        i_start_read  = ~we;
        i_line_addr   = idx;
        i_line_wdata  = wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            i_start_write = 1'b0;
            i_start_read  = 1'b0;
            cycles++;
        end while (!o_done);
        rdata = o_line_rdata;
        fault = o_fault;
        lines_done++;
        if (we) record_write(idx, wdata);
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            tests_ok++;
            $display("PASS: %s", name);
        end else begin
            tests_bad++;
            $display("FAIL: %s (%0d errors)", name, errors - err0);
        end
    endtask

    // --------------------
    // Tests.
    // --------------------
    task automatic test_write_readback();
        line_xfer_pkg::line_t wr [3];
        line_xfer_pkg::line_t rd;
        line_xfer_pkg::addr_t idx [3];
        logic fault;
        int   cyc;
        int   i;
        int   err0;
        err0 = errors;
        idx  = '{0, 3, 15};
        cfg_write(1'b0, '0);
        for (i = 0; i < 3; i++) begin
            next_line(wr[i]);
            run_line(1'b1, idx[i], wr[i], rd, fault, cyc);
            check_val("o_fault", fault, 1'b0);
            check_val("done latency", cyc, LINE_CYCLES);
        end
        for (i = 0; i < 3; i++) begin
            run_line(1'b0, idx[i], '0, rd, fault, cyc);
            check_val($sformatf("o_line_rdata line %0d", idx[i]), rd, wr[i]);
            check_val("o_fault", fault, 1'b0);
            check_val("done latency", cyc, LINE_CYCLES);
        end
        report_test("write and read back", err0);
    endtask

    task automatic test_base_offset();
        line_xfer_pkg::line_t wr;
        line_xfer_pkg::line_t rd;
        logic fault;
        int   cyc;
        int   err0;
        err0 = errors;
        next_line(wr);
        cfg_write(1'b0, 32'd16);
        run_line(1'b1, 0, wr, rd, fault, cyc);
        cfg_write(1'b0, '0);
        run_line(1'b0, 1, '0, rd, fault, cyc);
        check_val("o_line_rdata line 1", rd, wr);
        check_val("o_fault", fault, 1'b0);
        report_test("base offset", err0);
    endtask

    task automatic test_write_fault();
        line_xfer_pkg::line_t wr;
        line_xfer_pkg::line_t rd;
        line_xfer_pkg::line_t exp;
        line_xfer_pkg::line_t mask;
        line_xfer_pkg::word_t status;
        logic fault;
        int   cyc;
        int   i;
        int   err0;
        err0 = errors;
        cfg_write(1'b0, '0);
        next_line(wr);
        run_line(1'b1, 16, wr, rd, fault, cyc);
        check_val("o_fault", fault, 1'b1);
        read_status(status);
        check_val("STATUS write fault", status[1], 1'b1);
        for (i = 0; i < `XFER_BEATS; i++) begin
            run_line(1'b0, i, '0, rd, fault, cyc);
            expected_line(i, exp, mask);
            check_val($sformatf("o_line_rdata line %0d", i), rd & mask, exp);
            check_val("o_fault", fault, 1'b0);
        end
        report_test("write fault", err0);
    endtask

    task automatic test_read_fault();
        line_xfer_pkg::line_t rd;
        line_xfer_pkg::word_t status;
        logic fault;
        int   cyc;
        int   err0;
        err0 = errors;
        run_line(1'b0, 20, '0, rd, fault, cyc);
        check_val("o_fault", fault, 1'b1);
        check_val("o_line_rdata", rd, '0);
        read_status(status);
        check_val("STATUS read fault", status[0], 1'b1);
        report_test("read fault", err0);
    endtask

    task automatic test_busy_status();
        line_xfer_pkg::line_t wr;
        line_xfer_pkg::word_t status;
        int dones;
        int first;
        int cyc;
        int err0;
        err0  = errors;
        dones = 0;
        first = 0;
        cyc   = 0;
        next_line(wr);
        @(posedge clk);
        #1;
        i_start_write = 1'b1;
        i_line_addr   = 5;
        i_line_wdata  = wr;
        repeat (2 * LINE_CYCLES + 10) begin
            @(posedge clk);
            #1;
            i_start_write = 1'b0;
            cyc++;
            // A second strobe while busy must be dropped.
            if (cyc == 10) begin
                check_val("o_busy", o_busy, 1'b1);
                i_start_read = 1'b1;
                i_line_addr  = 7;
            end else begin
                i_start_read = 1'b0;
            end
            if (o_done) begin
                dones++;
                if (first == 0) first = cyc;
            end
        end
        check_val("o_done count", dones, 1);
        check_val("done latency", first, LINE_CYCLES);
        record_write(5, wr);
        lines_done++;
        read_status(status);
        check_val("STATUS line count", status[31:16], lines_done);
        cfg_write(1'b1, '0);
        read_status(status);
        check_val("STATUS after clear", status, '0);
        report_test("busy and status", err0);
    endtask

    // --------------------
    // Main sequence.
    // --------------------
    initial begin
        int i;
        i_rst_n       = 1'b0;
        i_start_read  = 1'b0;
        i_start_write = 1'b0;
        i_line_addr   = '0;
        i_line_wdata  = '0;
        i_cfg_we      = 1'b0;
        i_cfg_sel     = 1'b0;
        i_cfg_wdata   = '0;
        base_now      = '0;
        rng           = 32'h28dd_6851;
        for (i = 0; i < `XFER_MEM_WORDS; i++) begin
            known[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        i_rst_n = 1'b1;

        test_write_readback();
        test_base_offset();
        test_write_fault();
        test_read_fault();
        test_busy_status();

        $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/line_xfer_pkg.sv
rtl/xfer_cfg_regs.sv
rtl/line_serializer.sv
rtl/lite_bus_master.sv
rtl/word_mem.sv
rtl/line_xfer_top.sv
sim/tb_line_xfer.sv
